// File: Makefile
TOP = tb_quad_bram_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: compile.f
hw/quad_bram_pkg.sv
hw/job_sequencer.sv
hw/pfb_reader.sv
hw/seq_addr_gen.sv
hw/quad_bram_ctrl.sv
dv/tb_clk_gen.sv
dv/quad_bram_ctrl_assert.sv
dv/tb_quad_bram_ctrl.sv

// File: dv/quad_bram_ctrl_assert.sv
module quad_bram_ctrl_assert (
    input logic                       clk,
    input logic                       rst,
    input logic                       fetch_req,
    input quad_bram_pkg::fetch_resp_t fetch_resp,
    input logic                       pfb_rden,
    input quad_bram_pkg::seq_rd_t     seq_rd,
    input quad_bram_pkg::ce_mask_t    ce_execute
);

    // Credit balance and pending flag seen from the fetch interface
    quad_bram_pkg::credit_t credit_bal;
    logic                   pending;
    // Enough history for the read latency
    logic [1:0]             warm;

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_bal <= '0;
            pending    <= 1'b0;
            warm       <= '0;
        end else begin
            credit_bal <= credit_bal
                        + (fetch_resp.complete ? fetch_resp.credits : '0)
                        - quad_bram_pkg::credit_t'(pfb_rden);
            if (fetch_resp.complete) begin
                pending <= 1'b0;
            end else if (fetch_resp.ack) begin
                pending <= 1'b1;
            end
            if (warm != 2'd3) begin
                warm <= warm + 2'd1;
            end
        end
    end

    rden_has_credit: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> (credit_bal != '0))
        else $error("pfb_rden high with no credit left");

    req_not_pending: assert property (@(posedge clk) disable iff (rst)
        $rose(fetch_req) |-> !pending)
        else $error("fetch_req raised while a fetch is still pending");

    exec_follows_read: assert property (@(posedge clk) disable iff (rst)
        (warm == 2'd3) |-> (ce_execute[0] == $past(seq_rd.en, quad_bram_pkg::SEQ_RD_LATENCY)))
        else $error("ce_execute bit 0 does not follow the delayed sequence read");

endmodule

bind quad_bram_ctrl quad_bram_ctrl_assert u_quad_bram_ctrl_assert (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .fetch_resp (fetch_resp),
    .pfb_rden   (pfb_rden),
    .seq_rd     (seq_rd),
    .ce_execute (ce_execute)
);

// File: dv/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk
);

    // Period 8
    localparam int HALF_PERIOD = 4;

    logic clk_q = 1'b0;

    assign clk = clk_q;

    always #(HALF_PERIOD) clk_q = ~clk_q;

endmodule

// File: dv/tb_quad_bram_ctrl.sv
module tb_quad_bram_ctrl;

    localparam int          NUM_JOBS  = 6;
    localparam logic [15:0] LFSR_SEED = 16'd34646;
    // Largest padded map is 16 columns by 10 rows
    localparam int MAX_COLS = 16;
    localparam int MAX_ROWS = 10;
    // Up to 12 cycles of fetch overhead per word, then row execution and drain
    localparam int WORST_JOB = 12 * MAX_COLS * MAX_ROWS
                             + (MAX_ROWS - 2) * (quad_bram_pkg::SEQ_LEN * MAX_COLS
                             + quad_bram_pkg::SEQ_RD_LATENCY + quad_bram_pkg::NUM_CE + 4)
                             + 16;
    localparam int TIMEOUT_CYCLES = NUM_JOBS * WORST_JOB * 3 / 2;

    typedef struct packed {
        int         rd_words;
        int         prime_words;
        int         seq_reads;
        logic [1:0] gray;
    } expect_t;

    logic                        clk;
    logic                        rst;
    quad_bram_pkg::job_cfg_t     job_cfg;
    logic                        job_start;
    logic                        job_accept;
    logic                        job_complete;
    logic                        job_complete_ack;
    logic                        fetch_req;
    quad_bram_pkg::fetch_resp_t  fetch_resp;
    logic                        pfb_rden;
    quad_bram_pkg::seq_rd_t      seq_rd;
    quad_bram_pkg::ce_mask_t     ce_execute;
    quad_bram_pkg::gray_t        gray_code;

    int                      errors = 0;
    int                      checks = 0;
    int                      cycles = 0;
    logic [15:0]             stim_lfsr = LFSR_SEED;
    logic [15:0]             fetch_lfsr = LFSR_SEED;
    quad_bram_pkg::job_cfg_t cur_cfg;
    int                      words_owed = 0;

    // Per-job tallies kept by the compare process
    expect_t                 exp_job;
    int                      rd_count = 0;
    int                      seq_count = 0;
    int                      granted = 0;
    int                      addr_expect = 0;
    int                      accept_count = 0;
    int                      complete_count = 0;
    int                      ce_count [quad_bram_pkg::NUM_CE];
    logic [2:0]              en_hist;
    quad_bram_pkg::ce_mask_t ce_prev;
    logic                    complete_prev;

    tb_clk_gen u_tb_clk_gen (
        .clk (clk)
    );

    quad_bram_ctrl u_quad_bram_ctrl (
        .clk              (clk),
        .rst              (rst),
        .job_cfg          (job_cfg),
        .job_start        (job_start),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack),
        .fetch_req        (fetch_req),
        .fetch_resp       (fetch_resp),
        .pfb_rden         (pfb_rden),
        .seq_rd           (seq_rd),
        .ce_execute       (ce_execute),
        .gray_code        (gray_code)
    );

    ////////////////////
    // Helpers
    ////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    task automatic take_bits(inout logic [15:0] state, input int nbits, output int value);
        int b;
        value = 0;
        for (b = 0; b < nbits; b++) begin
            value = (value << 1) | int'(state[15]);
            state = lfsr_step(state);
        end
    endtask

    function automatic expect_t expected_counts(input quad_bram_pkg::job_cfg_t cfg);
        expect_t e;
        int      cols;
        int      rows;
        int      turns;
        cols          = int'(cfg.num_cols) + 1;
        rows          = int'(cfg.num_rows) + 1;
        e.rd_words    = rows * cols;
        e.prime_words = quad_bram_pkg::PRIME_ROWS * cols;
        // Two padding rows produce no output
        e.seq_reads   = quad_bram_pkg::SEQ_LEN * cols * (rows - 3);
        turns         = (rows - 4) % 4;
        e.gray        = 2'(turns ^ (turns >> 1));
        return e;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("error at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin : stimulus
        int job;
        int c;
        int r;
        int hold;
        rst              = 1'b1;
        job_start        = 1'b0;
        job_cfg          = '0;
        job_complete_ack = 1'b0;
        cur_cfg          = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        for (job = 0; job < NUM_JOBS; job++) begin
            take_bits(stim_lfsr, 4, c);
            take_bits(stim_lfsr, 3, r);
            cur_cfg.num_cols = quad_bram_pkg::dim_t'(c);
            cur_cfg.num_rows = quad_bram_pkg::dim_t'(3 + r % 7);
            words_owed       = (int'(cur_cfg.num_rows) + 1) * (c + 1);
            job_cfg          = cur_cfg;
            job_start        = 1'b1;
            @(negedge clk);
            job_start = 1'b0;
            check_value("job_accept", 1, int'(job_accept));
            @(negedge clk);
            check_value("job_accept", 0, int'(job_accept));

            while (!job_complete) begin
                @(negedge clk);
            end

            // A start while the job is still open must be ignored
            job_cfg   = ~cur_cfg;
            job_start = 1'b1;
            @(negedge clk);
            job_start = 1'b0;
            check_value("job_accept", 0, int'(job_accept));

            take_bits(stim_lfsr, 2, hold);
            repeat (hold) begin
                check_value("job_complete", 1, int'(job_complete));
                @(negedge clk);
            end
            check_value("job_complete", 1, int'(job_complete));
            job_complete_ack = 1'b1;
            @(negedge clk);
            job_complete_ack = 1'b0;
            check_value("job_complete", 0, int'(job_complete));
        end

        repeat (4) @(negedge clk);
        check_value("job_accept pulses", NUM_JOBS, accept_count);
        check_value("job_complete events", NUM_JOBS, complete_count);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    ////////////////////
    // Fetch engine model
    ////////////////////
    initial begin : fetch_engine
        int d;
        int n;
        fetch_resp = '0;
        forever begin
            @(negedge clk);
            if (fetch_req) begin
                take_bits(fetch_lfsr, 2, d);
                repeat (d) @(negedge clk);
                fetch_resp.ack = 1'b1;
                @(negedge clk);
                fetch_resp.ack = 1'b0;
                take_bits(fetch_lfsr, 2, d);
                repeat (d) @(negedge clk);
                take_bits(fetch_lfsr, 4, n);
                n = n + 1;
                if (words_owed == 0) begin
                    errors++;
                    $display("Fetch requested at %0t after every word was granted", $time);
                end else if (n > words_owed) begin
                    n = words_owed;
                end
                words_owed         = words_owed - n;
                fetch_resp.complete = 1'b1;
                fetch_resp.credits  = quad_bram_pkg::credit_t'(n);
                @(negedge clk);
                fetch_resp.complete = 1'b0;
                fetch_resp.credits  = '0;
            end
        end
    end

    ////////////////////
    // Compare
    ////////////////////
    always @(posedge clk) begin : compare
        int i;
        if (rst) begin
            en_hist       = '0;
            ce_prev       = '0;
            complete_prev = 1'b0;
        end else begin
            if (job_accept) begin
                accept_count++;
                exp_job     = expected_counts(cur_cfg);
                rd_count    = 0;
                seq_count   = 0;
                granted     = 0;
                addr_expect = 0;
                for (i = 0; i < quad_bram_pkg::NUM_CE; i++) begin
                    ce_count[i] = 0;
                end
            end

            // Credits from a completion this cycle pay only for later reads
            if (pfb_rden) begin
                rd_count++;
                if (rd_count > granted) begin
                    errors++;
                    $display("At %0t pfb_rden read a word that no fetch had granted", $time);
                end
            end
            if (fetch_resp.complete) begin
                granted = granted + int'(fetch_resp.credits);
            end

            if (seq_rd.en) begin
                seq_count++;
                check_value("seq_rd.addr", addr_expect, int'(seq_rd.addr));
                addr_expect = (addr_expect == quad_bram_pkg::SEQ_LEN - 1) ? 0 : addr_expect + 1;
                if (rd_count < exp_job.prime_words) begin
                    errors++;
                    $display("At %0t a sequence read began before the prime rows were in", $time);
                end
            end

            // Execute chain against delayed reads
            check_value("ce_execute[0]", int'(en_hist[2]), int'(ce_execute[0]));
            for (i = 1; i < quad_bram_pkg::NUM_CE; i++) begin
                check_value($sformatf("ce_execute[%0d]", i), int'(ce_prev[i-1]),
                            int'(ce_execute[i]));
            end
            for (i = 0; i < quad_bram_pkg::NUM_CE; i++) begin
                if (ce_execute[i]) begin
                    ce_count[i]++;
                end
            end

            if (job_complete && !complete_prev) begin
                complete_count++;
                check_value("pfb_rden count", exp_job.rd_words, rd_count);
                check_value("credits outstanding", 0, granted - rd_count);
                check_value("seq_rd.en count", exp_job.seq_reads, seq_count);
                for (i = 0; i < quad_bram_pkg::NUM_CE; i++) begin
                    check_value($sformatf("ce_execute[%0d] count", i), exp_job.seq_reads,
                                ce_count[i]);
                end
                check_value("gray_code", int'(exp_job.gray), int'(gray_code));
            end

            en_hist       = {en_hist[1:0], seq_rd.en};
            ce_prev       = ce_execute;
            complete_prev = job_complete;
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the jobs did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Result: FAILED");
            $finish;
        end
    end

endmodule

// File: hw/job_sequencer.sv
module job_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  quad_bram_pkg::job_cfg_t job_cfg,
    input  logic                    job_start,
    input  logic                    job_complete_ack,
    output logic                    job_accept,
    output logic                    job_complete,
    output quad_bram_pkg::job_cfg_t cfg,
    output logic                    load_start,
    output logic [2:0]              load_rows,
    input  logic                    load_done,
    output logic                    row_start,
    input  logic                    row_done,
    input  logic                    row_last,
    output quad_bram_pkg::gray_t    gray_code
);

    quad_bram_pkg::ctrl_state_e state;

    // Binary count of row-buffer rotations
    logic [1:0] rot_count;

    logic accept_now;

    // Start only counts while idle
    assign accept_now = (state == quad_bram_pkg::IDLE) && job_start;

    // Map size for the whole job
    always_ff @(posedge clk) begin
        if (accept_now) begin
            cfg <= job_cfg;
        end
    end

    ////////////////////
    // Job FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= quad_bram_pkg::IDLE;
            job_accept   <= 1'b0;
            job_complete <= 1'b0;
            load_start   <= 1'b0;
            load_rows    <= '0;
            row_start    <= 1'b0;
            rot_count    <= '0;
        end else begin
            job_accept <= 1'b0;
            load_start <= 1'b0;
            row_start  <= 1'b0;

            case (state)
                quad_bram_pkg::IDLE: begin
                    if (accept_now) begin
                        job_accept <= 1'b1;
                        rot_count  <= '0;
                        // Fill the quad before anything executes
                        load_start <= 1'b1;
                        load_rows  <= 3'(quad_bram_pkg::PRIME_ROWS);
                        state      <= quad_bram_pkg::PRIME;
                    end
                end

                quad_bram_pkg::PRIME: begin
                    if (load_done) begin
                        row_start <= 1'b1;
                        state     <= quad_bram_pkg::ACTIVE;
                    end
                end

                quad_bram_pkg::ACTIVE: begin
                    if (row_done) begin
                        if (row_last) begin
                            job_complete <= 1'b1;
                            state        <= quad_bram_pkg::DONE;
                        end else begin
                            // Bring in the next input row
                            load_start <= 1'b1;
                            load_rows  <= 3'd1;
                            state      <= quad_bram_pkg::LOAD_ROW;
                        end
                    end
                end

                quad_bram_pkg::LOAD_ROW: begin
                    if (load_done) begin
                        // New row replaces the oldest buffer
                        rot_count <= rot_count + 2'd1;
                        row_start <= 1'b1;
                        state     <= quad_bram_pkg::ACTIVE;
                    end
                end

                quad_bram_pkg::DONE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= quad_bram_pkg::IDLE;
                    end
                end

                default: begin
                    state <= quad_bram_pkg::IDLE;
                end
            endcase
        end
    end

    // Gray form of the rotation count
    assign gray_code = {rot_count[1], rot_count[1] ^ rot_count[0]};

endmodule

// File: hw/pfb_reader.sv
module pfb_reader (
    input  logic                       clk,
    input  logic                       rst,
    input  quad_bram_pkg::job_cfg_t    cfg,
    input  logic                       load_start,
    input  logic [2:0]                 load_rows,
    output logic                       load_done,
    output logic                       fetch_req,
    input  quad_bram_pkg::fetch_resp_t fetch_resp,
    output logic                       pfb_rden
);

    // Up to eight rows of 512 words
    localparam int WL_W = quad_bram_pkg::DIM_W + 3;

    logic [WL_W-1:0]        words_left;
    logic [WL_W-1:0]        load_words;
    quad_bram_pkg::credit_t credits;
    logic                   pending;
    quad_bram_pkg::dim_t    in_col;
    quad_bram_pkg::dim_t    in_row;
    logic                   new_map;

    assign load_words = WL_W'(load_rows) * (WL_W'(cfg.num_cols) + WL_W'(1));

    // A prime load begins a fresh map
    assign new_map = load_start && (load_rows == 3'(quad_bram_pkg::PRIME_ROWS));

    // Read whenever a word is owed and paid for
    // Never past the bottom padded row
    assign pfb_rden = (words_left != '0) && (credits != '0) && (in_row <= cfg.num_rows);

    ////////////////////
    // Fetch handshake
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_req <= 1'b0;
            pending   <= 1'b0;
        end else begin
            if (fetch_resp.ack) begin
                fetch_req <= 1'b0;
            end else if ((words_left != '0) && (credits == '0) && !pending) begin
                fetch_req <= 1'b1;
            end

            if (fetch_resp.complete) begin
                pending <= 1'b0;
            end else if (fetch_resp.ack) begin
                pending <= 1'b1;
            end
        end
    end

    // Grants add on complete, each read spends one
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= '0;
        end else begin
            credits <= credits
                     + (fetch_resp.complete ? fetch_resp.credits : '0)
                     - quad_bram_pkg::credit_t'(pfb_rden);
        end
    end

    ////////////////////
    // Load tracking
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            words_left <= '0;
            load_done  <= 1'b0;
        end else begin
            load_done <= pfb_rden && (words_left == WL_W'(1));
            if (load_start) begin
                words_left <= load_words;
            end else if (pfb_rden) begin
                words_left <= words_left - WL_W'(1);
            end
        end
    end

    // Input position in the padded map
    always_ff @(posedge clk) begin
        if (rst) begin
            in_col <= '0;
            in_row <= '0;
        end else if (new_map) begin
            in_col <= '0;
            in_row <= '0;
        end else if (pfb_rden) begin
            if (in_col == cfg.num_cols) begin
                in_col <= '0;
                in_row <= in_row + quad_bram_pkg::dim_t'(1);
            end else begin
                in_col <= in_col + quad_bram_pkg::dim_t'(1);
            end
        end
    end

endmodule

// File: hw/quad_bram_ctrl.sv
module quad_bram_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  quad_bram_pkg::job_cfg_t    job_cfg,
    input  logic                       job_start,
    output logic                       job_accept,
    output logic                       job_complete,
    input  logic                       job_complete_ack,
    output logic                       fetch_req,
    input  quad_bram_pkg::fetch_resp_t fetch_resp,
    output logic                       pfb_rden,
    output quad_bram_pkg::seq_rd_t     seq_rd,
    output quad_bram_pkg::ce_mask_t    ce_execute,
    output quad_bram_pkg::gray_t       gray_code
);

    // Latched job configuration
    quad_bram_pkg::job_cfg_t cfg;

    // Prefetch load control
    logic       load_start;
    logic [2:0] load_rows;
    logic       load_done;

    // Output row control
    logic row_start;
    logic row_done;
    logic row_last;

    ////////////////////
    // Job FSM
    ////////////////////
    job_sequencer u_job_sequencer (
        .clk              (clk),
        .rst              (rst),
        .job_cfg          (job_cfg),
        .job_start        (job_start),
        .job_complete_ack (job_complete_ack),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .cfg              (cfg),
        .load_start       (load_start),
        .load_rows        (load_rows),
        .load_done        (load_done),
        .row_start        (row_start),
        .row_done         (row_done),
        .row_last         (row_last),
        .gray_code        (gray_code)
    );

    ////////////////////
    // Prefetch side
    ////////////////////
    pfb_reader u_pfb_reader (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .load_start (load_start),
        .load_rows  (load_rows),
        .load_done  (load_done),
        .fetch_req  (fetch_req),
        .fetch_resp (fetch_resp),
        .pfb_rden   (pfb_rden)
    );

    ////////////////////
    // Execute side
    ////////////////////
    seq_addr_gen u_seq_addr_gen (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .row_start  (row_start),
        .row_done   (row_done),
        .row_last   (row_last),
        .seq_rd     (seq_rd),
        .ce_execute (ce_execute)
    );

endmodule

// File: hw/quad_bram_pkg.sv
package quad_bram_pkg;

    ////////////////////
    // Array geometry
    ////////////////////
    localparam int NUM_AWE        = 4;
    localparam int NUM_CE_PER_AWE = 2;
    localparam int NUM_CE         = NUM_AWE * NUM_CE_PER_AWE;

    // Padded map indices
    localparam int DIM_W = 9;

    // Sequence memory
    localparam int SEQ_LEN        = 5;
    localparam int SEQ_ADDR_W     = 12;
    localparam int SEQ_RD_LATENCY = 3;

    // Rows held in the quad before the first output row
    localparam int PRIME_ROWS = 4;

    // One fetch grants at most 511 words
    localparam int CREDIT_W = 9;

    ////////////////////
    // Types
    ////////////////////
    typedef logic [DIM_W-1:0]      dim_t;
    typedef logic [CREDIT_W-1:0]   credit_t;
    typedef logic [SEQ_ADDR_W-1:0] seq_addr_t;
    typedef logic [NUM_CE-1:0]     ce_mask_t;
    typedef logic [1:0]            gray_t;

    // Last index of the padded map in each direction
    typedef struct packed {
        dim_t num_cols;
        dim_t num_rows;
    } job_cfg_t;

    typedef struct packed {
        logic    ack;
        logic    complete;
        credit_t credits;
    } fetch_resp_t;

    typedef struct packed {
        logic      en;
        seq_addr_t addr;
    } seq_rd_t;

    typedef enum logic [2:0] {
        IDLE,
        PRIME,
        ACTIVE,
        LOAD_ROW,
        DONE
    } ctrl_state_e;

endpackage

// File: hw/seq_addr_gen.sv
module seq_addr_gen (
    input  logic                    clk,
    input  logic                    rst,
    input  quad_bram_pkg::job_cfg_t cfg,
    input  logic                    row_start,
    output logic                    row_done,
    output logic                    row_last,
    output quad_bram_pkg::seq_rd_t  seq_rd,
    output quad_bram_pkg::ce_mask_t ce_execute
);

    localparam int CYC_W = $clog2(quad_bram_pkg::SEQ_LEN);
    // Final chain stage is ce_execute bit 0 itself
    localparam int LAT_W = quad_bram_pkg::SEQ_RD_LATENCY - 1;

    logic                rd_en;
    logic [CYC_W-1:0]    cyc;
    quad_bram_pkg::dim_t out_col;
    quad_bram_pkg::dim_t out_row;
    quad_bram_pkg::dim_t last_row;
    logic [LAT_W-1:0]    lat_pipe;
    logic                draining;
    logic                pixel_end;

    assign pixel_end = (cyc == CYC_W'(quad_bram_pkg::SEQ_LEN - 1));

    // Two padding rows give no output row
    assign last_row = cfg.num_rows - quad_bram_pkg::dim_t'(3);
    assign row_last = (out_row == last_row);

    // Address is the read index within the pixel
    assign seq_rd.en   = rd_en;
    assign seq_rd.addr = quad_bram_pkg::seq_addr_t'(cyc);

    ////////////////////
    // Read sequencing
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en    <= 1'b0;
            cyc      <= '0;
            out_col  <= '0;
            draining <= 1'b0;
        end else if (row_start) begin
            rd_en   <= 1'b1;
            cyc     <= '0;
            out_col <= '0;
        end else if (rd_en) begin
            if (pixel_end) begin
                cyc <= '0;
                if (out_col == cfg.num_cols) begin
                    // Last read of the row just went out
                    rd_en    <= 1'b0;
                    out_col  <= '0;
                    draining <= 1'b1;
                end else begin
                    out_col <= out_col + quad_bram_pkg::dim_t'(1);
                end
            end else begin
                cyc <= cyc + CYC_W'(1);
            end
        end else if (row_done) begin
            draining <= 1'b0;
        end
    end

    // Output row advances once the row has fully drained
    always_ff @(posedge clk) begin
        if (rst) begin
            out_row <= '0;
        end else if (row_done) begin
            out_row <= row_last ? '0 : out_row + quad_bram_pkg::dim_t'(1);
        end
    end

    ////////////////////
    // Execute chain
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            lat_pipe   <= '0;
            ce_execute <= '0;
        end else begin
            // Covers the sequence memory read latency
            lat_pipe   <= (lat_pipe << 1) | LAT_W'(rd_en);
            ce_execute <= {ce_execute[quad_bram_pkg::NUM_CE-2:0], lat_pipe[LAT_W-1]};
        end
    end

    // Done when nothing is left in flight
    assign row_done = draining && !rd_en && (lat_pipe == '0) && (ce_execute == '0);

endmodule
